//--- build.f
+incdir+.
cpu_pkg.sv
reg_file.sv
if_stage.sv
id_stage.sv
lsu_wb_stage.sv
sram_arbiter.sv
cpu_soc_top.sv
cpu_soc_asserts.sv
cpu_soc_tb.sv

//--- Bender.yml
package:
  name: cpu_soc

export_include_dirs:
  - .

sources:
  - files:
      - cpu_pkg.sv
      - reg_file.sv
      - if_stage.sv
      - id_stage.sv
      - lsu_wb_stage.sv
      - sram_arbiter.sv
      - cpu_soc_top.sv
  - target: test
    files:
      - cpu_soc_asserts.sv
      - cpu_soc_tb.sv

//--- cpu_soc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_soc_tb;
    localparam int N_PROG     = 14;
    localparam int N_TRACE    = 7;
    localparam int N_STORE    = 2;
    localparam int MAX_CYCLES = N_PROG * 40 + 8;

    logic               clk;
    logic               arst_n;
    logic               mem_req;
    logic               mem_wr;
    logic [`XLEN-1:0]   mem_addr;
    logic [`XLEN-1:0]   mem_wdata;
    logic [`XLEN-1:0]   mem_rdata;
    logic               mem_addr_ok;
    logic               mem_data_ok;
    logic [`XLEN-1:0]   debug_wb_pc;
    logic [3:0]         debug_wb_rf_we;
    logic [`REG_AW-1:0] debug_wb_rf_wnum;
    logic [`XLEN-1:0]   debug_wb_rf_wdata;

    logic [`XLEN-1:0]   mem [0:255];  // word index is addr[9:2]
    logic [`XLEN-1:0]   prog [0:N_PROG-1];
    logic [`XLEN-1:0]   exp_pc [0:N_TRACE-1];
    logic [`REG_AW-1:0] exp_wnum [0:N_TRACE-1];
    logic [`XLEN-1:0]   exp_wdata [0:N_TRACE-1];
    logic [`XLEN-1:0]   exp_st_addr [0:N_STORE-1];
    logic [`XLEN-1:0]   exp_st_data [0:N_STORE-1];
    integer             seed;
    int                 trace_idx;
    int                 store_cnt;
    int                 cycles;
    logic               first_req;

    cpu_soc_top u_dut (.*);

    function automatic logic [`XLEN-1:0] encode(input cpu_pkg::op_e op, input logic [4:0] rd,
                                                input logic [4:0] rj, input logic [15:0] imm);
        logic [`XLEN-1:0] word;
        case (op)
            cpu_pkg::OP_ADD:  word = {`OPC_ADD_W, imm[4:0], rj, rd};  // imm carries rk
            cpu_pkg::OP_ADDI: word = {`OPC_ADDI_W, imm[11:0], rj, rd};
            cpu_pkg::OP_LD:   word = {`OPC_LD_W, imm[11:0], rj, rd};
            cpu_pkg::OP_ST:   word = {`OPC_ST_W, imm[11:0], rj, rd};
            cpu_pkg::OP_BEQ:  word = {`OPC_BEQ, imm, rj, rd};
            default:          word = '0;
        endcase
        return word;
    endfunction

    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "run aborted");
    endtask

    task automatic check_trace(input logic [`XLEN-1:0] pc, input logic [`REG_AW-1:0] wnum,
                               input logic [`XLEN-1:0] wdata);
        if (debug_wb_pc !== pc || debug_wb_rf_wnum !== wnum || debug_wb_rf_wdata !== wdata) begin
            report_error($sformatf("trace pc %h r%0d %h, expected pc %h r%0d %h",
                                   debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
                                   pc, wnum, wdata));
        end
    endtask

    task automatic check_mem(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] word);
        if (mem[addr[9:2]] !== word) begin
            report_error($sformatf("mem[%h] is %h, expected %h", addr, mem[addr[9:2]], word));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : watchdog
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                abort_run($sformatf("timeout: program not finished after %0d cycles", cycles));
            end
        end
    end

    // one request at a time, random wait before addr_ok and before data_ok
    initial begin : mem_model
        int               delay;
        int               k;
        logic             acc_wr;
        logic [`XLEN-1:0] acc_addr;
        logic [`XLEN-1:0] acc_wdata;
        forever begin
            @(negedge clk);
            if (arst_n && mem_req) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #1 mem_addr_ok = 1'b1;
                @(negedge clk);
                if (!mem_req) begin
                    abort_run("memory request dropped while waiting for addr_ok");
                end
                acc_wr    = mem_wr;
                acc_addr  = mem_addr;
                acc_wdata = mem_wdata;
                if (first_req && acc_addr !== `RESET_PC) begin
                    report_error($sformatf("first fetch at %h, expected %h", acc_addr, `RESET_PC));
                end
                first_req = 1'b0;
                @(posedge clk);  // accepted here
                #1 mem_addr_ok = 1'b0;
                if (acc_wr) begin
                    mem[acc_addr[9:2]] = acc_wdata;
                    store_cnt++;
                end else begin
                    mem_rdata = mem[acc_addr[9:2]];
                end
                delay = 1 + $unsigned($random(seed)) % 3;
                for (k = 1; k < delay; k++) begin
                    @(posedge clk);
                    #1;
                end
                mem_data_ok = 1'b1;
                @(posedge clk);
                #1 mem_data_ok = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (!arst_n) begin
            if (mem_req !== 1'b0 || debug_wb_rf_we !== 4'h0) begin
                abort_run("bus request or trace active during reset");
            end
        end else if (debug_wb_rf_we !== 4'h0) begin
            if (debug_wb_rf_we !== 4'hf) begin
                abort_run("trace write enable is not all ones");
            end else if (trace_idx >= N_TRACE) begin
                report_error($sformatf("extra trace entry at pc %h", debug_wb_pc));
            end else begin
                check_trace(exp_pc[trace_idx], exp_wnum[trace_idx], exp_wdata[trace_idx]);
            end
            trace_idx++;
        end
    end

    initial begin : main
        int i;
        arst_n      = 1'b1;
        mem_rdata   = '0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        seed        = 2;
        trace_idx   = 0;
        store_cnt   = 0;
        first_req   = 1'b1;

        prog[0]  = encode(cpu_pkg::OP_ADDI, 5'd1, 5'd0, 16'h0100);
        prog[1]  = encode(cpu_pkg::OP_ADDI, 5'd2, 5'd0, 16'h0ffb);  // -5
        prog[2]  = encode(cpu_pkg::OP_ADD,  5'd3, 5'd1, 16'd2);
        prog[3]  = encode(cpu_pkg::OP_ADDI, 5'd0, 5'd1, 16'd5);     // r0 write, no trace
        prog[4]  = encode(cpu_pkg::OP_ADD,  5'd4, 5'd0, 16'd3);
        prog[5]  = encode(cpu_pkg::OP_ST,   5'd3, 5'd1, 16'd8);
        prog[6]  = encode(cpu_pkg::OP_LD,   5'd5, 5'd1, 16'd8);
        prog[7]  = encode(cpu_pkg::OP_ADD,  5'd6, 5'd5, 16'd5);     // needs the load
        prog[8]  = encode(cpu_pkg::OP_BEQ,  5'd3, 5'd5, 16'd2);     // taken to pc 10
        prog[9]  = encode(cpu_pkg::OP_ADDI, 5'd7, 5'd0, 16'd1);     // skipped
        prog[10] = encode(cpu_pkg::OP_BEQ,  5'd2, 5'd1, 16'd2);     // not taken
        prog[11] = encode(cpu_pkg::OP_ADDI, 5'd8, 5'd6, 16'h0010);
        prog[12] = encode(cpu_pkg::OP_ST,   5'd8, 5'd0, 16'h010c);
        prog[13] = encode(cpu_pkg::OP_BEQ,  5'd0, 5'd0, 16'd0);     // spin
        for (i = 0; i < 256; i++) begin
            mem[i] = '0;
        end
        for (i = 0; i < N_PROG; i++) begin
            mem[i] = prog[i];
        end

        // pc, register, value in program order
        exp_pc[0] = `RESET_PC + 32'd0;   exp_wnum[0] = 5'd1;  exp_wdata[0] = 32'h0000_0100;
        exp_pc[1] = `RESET_PC + 32'd4;   exp_wnum[1] = 5'd2;  exp_wdata[1] = 32'hffff_fffb;
        exp_pc[2] = `RESET_PC + 32'd8;   exp_wnum[2] = 5'd3;  exp_wdata[2] = 32'h0000_00fb;
        exp_pc[3] = `RESET_PC + 32'd16;  exp_wnum[3] = 5'd4;  exp_wdata[3] = 32'h0000_00fb;
        exp_pc[4] = `RESET_PC + 32'd24;  exp_wnum[4] = 5'd5;  exp_wdata[4] = 32'h0000_00fb;
        exp_pc[5] = `RESET_PC + 32'd28;  exp_wnum[5] = 5'd6;  exp_wdata[5] = 32'h0000_01f6;
        exp_pc[6] = `RESET_PC + 32'd44;  exp_wnum[6] = 5'd8;  exp_wdata[6] = 32'h0000_0206;
        exp_st_addr[0] = 32'h0000_0108;  exp_st_data[0] = 32'h0000_00fb;
        exp_st_addr[1] = 32'h0000_010c;  exp_st_data[1] = 32'h0000_0206;

        #1 arst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;

        wait (trace_idx == N_TRACE && store_cnt == N_STORE);
        repeat (10) @(posedge clk);  // room for a stray trace entry
        for (i = 0; i < N_STORE; i++) begin
            check_mem(exp_st_addr[i], exp_st_data[i]);
        end

        $display("** PASS **");
        $finish;
    end
endmodule

`default_nettype wire

//--- cpu_soc_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_soc_asserts (
    input logic                clk,
    input logic                arst_n,
    input cpu_pkg::arb_state_e arb_state,
    input logic                mem_req,
    input logic                mem_wr,
    input logic [`XLEN-1:0]    mem_addr,
    input logic                mem_addr_ok,
    input logic                mem_data_ok,
    input logic                inst_req,
    input logic                inst_addr_ok,
    input logic                inst_data_ok,
    input logic                data_req,
    input logic                data_addr_ok,
    input logic                data_data_ok
);
    logic inst_pend;  // accepted fetch not yet answered
    logic data_pend;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inst_pend <= 1'b0;
            data_pend <= 1'b0;
        end else begin
            if (inst_req && inst_addr_ok) begin
                inst_pend <= 1'b1;
            end else if (inst_data_ok) begin
                inst_pend <= 1'b0;
            end
            if (data_req && data_addr_ok) begin
                data_pend <= 1'b1;
            end else if (data_data_ok) begin
                data_pend <= 1'b0;
            end
        end
    end

    // a waiting request holds its address and direction
    req_held: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_req && !mem_addr_ok) |=> (mem_req && $stable(mem_addr) && $stable(mem_wr)))
        else $error("mem request changed before addr_ok");

    idle_no_resp: assert property (@(posedge clk) disable iff (!arst_n)
        (arb_state == cpu_pkg::ARB_IDLE) |-> !mem_data_ok)
        else $error("mem_data_ok with no owner");

    inst_owner: assert property (@(posedge clk) disable iff (!arst_n)
        inst_data_ok |-> inst_pend)
        else $error("inst_data_ok without ownership");

    data_owner: assert property (@(posedge clk) disable iff (!arst_n)
        data_data_ok |-> data_pend)
        else $error("data_data_ok without ownership");
endmodule

bind sram_arbiter cpu_soc_asserts u_asserts (
    .clk          (clk),
    .arst_n       (arst_n),
    .arb_state    (arb_state),
    .mem_req      (mem_req),
    .mem_wr       (mem_wr),
    .mem_addr     (mem_addr),
    .mem_addr_ok  (mem_addr_ok),
    .mem_data_ok  (mem_data_ok),
    .inst_req     (inst_req),
    .inst_addr_ok (inst_addr_ok),
    .inst_data_ok (inst_data_ok),
    .data_req     (data_req),
    .data_addr_ok (data_addr_ok),
    .data_data_ok (data_data_ok)
);

`default_nettype wire

//--- cpu_soc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_soc_top (
    input  logic               clk,
    input  logic               arst_n,
    output logic               mem_req,
    output logic               mem_wr,
    output logic [`XLEN-1:0]   mem_addr,
    output logic [`XLEN-1:0]   mem_wdata,
    input  logic [`XLEN-1:0]   mem_rdata,
    input  logic               mem_addr_ok,
    input  logic               mem_data_ok,
    output logic [`XLEN-1:0]   debug_wb_pc,
    output logic [3:0]         debug_wb_rf_we,
    output logic [`REG_AW-1:0] debug_wb_rf_wnum,
    output logic [`XLEN-1:0]   debug_wb_rf_wdata
);
    // instruction master
    logic               inst_req;
    logic               inst_wr;
    logic [`XLEN-1:0]   inst_addr;
    logic [`XLEN-1:0]   inst_wdata;
    logic [`XLEN-1:0]   inst_rdata;
    logic               inst_addr_ok;
    logic               inst_data_ok;
    // data master
    logic               data_req;
    logic               data_wr;
    logic [`XLEN-1:0]   data_addr;
    logic [`XLEN-1:0]   data_wdata;
    logic [`XLEN-1:0]   data_rdata;
    logic               data_addr_ok;
    logic               data_data_ok;
    // stage handshake and payload
    logic               ds_allowin;
    logic               es_allowin;
    logic               fs_to_ds_valid;
    logic               ds_to_es_valid;
    logic               br_taken;
    logic [`XLEN-1:0]   br_target;
    logic [`XLEN-1:0]   fs_inst;
    logic [`XLEN-1:0]   fs_pc;
    cpu_pkg::op_e       es_op;
    logic [`XLEN-1:0]   es_pc;
    logic [`XLEN-1:0]   es_result;
    logic [`XLEN-1:0]   es_store_data;
    logic [`REG_AW-1:0] es_dest;
    logic               ms_pend_valid;
    logic [`REG_AW-1:0] ms_pend_dest;
    // register file
    logic [`REG_AW-1:0] rf_raddr1;
    logic [`REG_AW-1:0] rf_raddr2;
    logic [`XLEN-1:0]   rf_rdata1;
    logic [`XLEN-1:0]   rf_rdata2;
    logic               rf_we;
    logic [`REG_AW-1:0] rf_waddr;
    logic [`XLEN-1:0]   rf_wdata;

    if_stage u_if (.*);

    id_stage u_id (.*);

    lsu_wb_stage u_lsu (.*);

    reg_file u_rf (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (rf_raddr2),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    sram_arbiter u_arb (.*);
endmodule

`default_nettype wire

//--- sram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module sram_arbiter (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             inst_req,
    input  logic             inst_wr,
    input  logic [`XLEN-1:0] inst_addr,
    input  logic [`XLEN-1:0] inst_wdata,
    output logic [`XLEN-1:0] inst_rdata,
    output logic             inst_addr_ok,
    output logic             inst_data_ok,
    input  logic             data_req,
    input  logic             data_wr,
    input  logic [`XLEN-1:0] data_addr,
    input  logic [`XLEN-1:0] data_wdata,
    output logic [`XLEN-1:0] data_rdata,
    output logic             data_addr_ok,
    output logic             data_data_ok,
    output logic             mem_req,
    output logic             mem_wr,
    output logic [`XLEN-1:0] mem_addr,
    output logic [`XLEN-1:0] mem_wdata,
    input  logic [`XLEN-1:0] mem_rdata,
    input  logic             mem_addr_ok,
    input  logic             mem_data_ok
);
    cpu_pkg::arb_state_e arb_state;
    logic                sel_data;

    // data wins in idle, owner locked until its data_ok
    assign sel_data = (arb_state == cpu_pkg::ARB_WAIT_DATA) ||
                      ((arb_state == cpu_pkg::ARB_IDLE) && data_req);

    assign mem_req   = sel_data ? data_req   : inst_req;
    assign mem_wr    = sel_data ? data_wr    : inst_wr;
    assign mem_addr  = sel_data ? data_addr  : inst_addr;
    assign mem_wdata = sel_data ? data_wdata : inst_wdata;

    assign data_addr_ok = sel_data && mem_addr_ok;
    assign inst_addr_ok = !sel_data && mem_addr_ok;
    assign data_data_ok = (arb_state == cpu_pkg::ARB_WAIT_DATA) && mem_data_ok;
    assign inst_data_ok = (arb_state == cpu_pkg::ARB_WAIT_INST) && mem_data_ok;
    assign data_rdata   = mem_rdata;
    assign inst_rdata   = mem_rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arb_state <= cpu_pkg::ARB_IDLE;
        end else begin
            case (arb_state)
                cpu_pkg::ARB_IDLE: begin
                    if (data_req) begin
                        arb_state <= cpu_pkg::ARB_WAIT_DATA;
                    end else if (inst_req) begin
                        arb_state <= cpu_pkg::ARB_WAIT_INST;
                    end
                end
                default: begin
                    if (mem_data_ok) begin
                        arb_state <= cpu_pkg::ARB_IDLE;
                    end
                end
            endcase
        end
    end
endmodule

`default_nettype wire

//--- lsu_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module lsu_wb_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               ds_to_es_valid,
    output logic               es_allowin,
    input  cpu_pkg::op_e       es_op,
    input  logic [`XLEN-1:0]   es_pc,
    input  logic [`XLEN-1:0]   es_result,
    input  logic [`XLEN-1:0]   es_store_data,
    input  logic [`REG_AW-1:0] es_dest,
    output logic               data_req,
    output logic               data_wr,
    output logic [`XLEN-1:0]   data_addr,
    output logic [`XLEN-1:0]   data_wdata,
    input  logic [`XLEN-1:0]   data_rdata,
    input  logic               data_addr_ok,
    input  logic               data_data_ok,
    output logic               rf_we,
    output logic [`REG_AW-1:0] rf_waddr,
    output logic [`XLEN-1:0]   rf_wdata,
    output logic               ms_pend_valid,
    output logic [`REG_AW-1:0] ms_pend_dest,
    output logic [`XLEN-1:0]   debug_wb_pc,
    output logic [3:0]         debug_wb_rf_we,
    output logic [`REG_AW-1:0] debug_wb_rf_wnum,
    output logic [`XLEN-1:0]   debug_wb_rf_wdata
);
    logic               ms_valid;
    logic               ms_req_sent;
    cpu_pkg::op_e       ms_op;
    logic [`XLEN-1:0]   ms_pc;
    logic [`XLEN-1:0]   ms_result;
    logic [`XLEN-1:0]   ms_store_data;
    logic [`REG_AW-1:0] ms_dest;
    logic               ms_mem;
    logic               ms_ready_go;

    assign ms_mem      = (ms_op == cpu_pkg::OP_LD) || (ms_op == cpu_pkg::OP_ST);
    assign ms_ready_go = !ms_mem || (ms_req_sent && data_data_ok);
    assign es_allowin  = !ms_valid || ms_ready_go;

    assign data_req   = ms_valid && ms_mem && !ms_req_sent;
    assign data_wr    = (ms_op == cpu_pkg::OP_ST);
    assign data_addr  = ms_result;
    assign data_wdata = ms_store_data;

    // r0 targets never count as a write
    assign ms_pend_valid = ms_valid && (ms_dest != '0) &&
                           ((ms_op == cpu_pkg::OP_ADD) || (ms_op == cpu_pkg::OP_ADDI) ||
                            (ms_op == cpu_pkg::OP_LD));
    assign ms_pend_dest  = ms_dest;

    assign rf_we    = ms_pend_valid && ms_ready_go;
    assign rf_waddr = ms_dest;
    assign rf_wdata = (ms_op == cpu_pkg::OP_LD) ? data_rdata : ms_result;

    assign debug_wb_pc       = ms_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ms_valid    <= 1'b0;
            ms_req_sent <= 1'b0;
        end else begin
            if (es_allowin) begin
                ms_valid <= ds_to_es_valid;
            end
            if (ds_to_es_valid && es_allowin) begin
                ms_req_sent <= 1'b0;
            end else if (data_req && data_addr_ok) begin
                ms_req_sent <= 1'b1;  // now waiting on data_ok
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            ms_op         <= es_op;
            ms_pc         <= es_pc;
            ms_result     <= es_result;
            ms_store_data <= es_store_data;
            ms_dest       <= es_dest;
        end
    end
endmodule

`default_nettype wire

//--- id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module id_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               fs_to_ds_valid,
    input  logic [`XLEN-1:0]   fs_inst,
    input  logic [`XLEN-1:0]   fs_pc,
    output logic               ds_allowin,
    output logic               br_taken,
    output logic [`XLEN-1:0]   br_target,
    output logic [`REG_AW-1:0] rf_raddr1,
    output logic [`REG_AW-1:0] rf_raddr2,
    input  logic [`XLEN-1:0]   rf_rdata1,
    input  logic [`XLEN-1:0]   rf_rdata2,
    input  logic               es_allowin,
    output logic               ds_to_es_valid,
    output cpu_pkg::op_e       es_op,
    output logic [`XLEN-1:0]   es_pc,
    output logic [`XLEN-1:0]   es_result,
    output logic [`XLEN-1:0]   es_store_data,
    output logic [`REG_AW-1:0] es_dest,
    input  logic               ms_pend_valid,
    input  logic [`REG_AW-1:0] ms_pend_dest
);
    logic             ds_valid;
    logic [`XLEN-1:0] ds_inst;
    logic [`XLEN-1:0] ds_pc;
    cpu_pkg::op_e     ds_op;
    logic             use_r2;
    logic             stall;
    logic             ds_ready_go;
    logic [`XLEN-1:0] imm12;
    logic [`XLEN-1:0] offs;

    assign ds_op = (ds_inst[31:15] == `OPC_ADD_W)  ? cpu_pkg::OP_ADD  :
                   (ds_inst[31:22] == `OPC_ADDI_W) ? cpu_pkg::OP_ADDI :
                   (ds_inst[31:22] == `OPC_LD_W)   ? cpu_pkg::OP_LD   :
                   (ds_inst[31:22] == `OPC_ST_W)   ? cpu_pkg::OP_ST   :
                   (ds_inst[31:26] == `OPC_BEQ)    ? cpu_pkg::OP_BEQ  :
                                                     cpu_pkg::OP_NOP;

    // second source is rk for add.w, rd for st.w and beq
    assign rf_raddr1 = ds_inst[9:5];
    assign rf_raddr2 = (ds_op == cpu_pkg::OP_ADD) ? ds_inst[14:10] : ds_inst[4:0];
    assign use_r2    = (ds_op == cpu_pkg::OP_ADD) || (ds_op == cpu_pkg::OP_ST) ||
                       (ds_op == cpu_pkg::OP_BEQ);

    // no forwarding, wait for the write back
    assign stall = ms_pend_valid && (ds_op != cpu_pkg::OP_NOP) &&
                   ((rf_raddr1 == ms_pend_dest) || (use_r2 && rf_raddr2 == ms_pend_dest));
    assign ds_ready_go    = !stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    assign imm12 = {{20{ds_inst[21]}}, ds_inst[21:10]};
    assign offs  = {{14{ds_inst[25]}}, ds_inst[25:10], 2'b00};

    assign es_op         = ds_op;
    assign es_pc         = ds_pc;
    assign es_result     = (ds_op == cpu_pkg::OP_ADD) ? rf_rdata1 + rf_rdata2 : rf_rdata1 + imm12;
    assign es_store_data = rf_rdata2;
    assign es_dest       = ds_inst[4:0];

    assign br_target = ds_pc + offs;
    assign br_taken  = ds_to_es_valid && es_allowin && (ds_op == cpu_pkg::OP_BEQ) &&
                       (rf_rdata1 == rf_rdata2);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid && !br_taken;  // squash the slot after a taken beq
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end
endmodule

`default_nettype wire

//--- if_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module if_stage (
    input  logic             clk,
    input  logic             arst_n,
    output logic             inst_req,
    output logic             inst_wr,
    output logic [`XLEN-1:0] inst_addr,
    output logic [`XLEN-1:0] inst_wdata,
    input  logic [`XLEN-1:0] inst_rdata,
    input  logic             inst_addr_ok,
    input  logic             inst_data_ok,
    input  logic             ds_allowin,
    input  logic             br_taken,
    input  logic [`XLEN-1:0] br_target,
    output logic             fs_to_ds_valid,
    output logic [`XLEN-1:0] fs_inst,
    output logic [`XLEN-1:0] fs_pc
);
    logic             fs_req;
    logic             fs_busy;
    logic             fs_full;
    logic             fs_cancel;
    logic             fs_redir;
    logic [`XLEN-1:0] redir_pc;
    logic [`XLEN-1:0] pc;
    logic             req_fire;
    logic             req_wait;
    logic             busy_n;
    logic             full_n;

    assign req_fire = fs_req && inst_addr_ok;
    assign req_wait = fs_req && !inst_addr_ok;
    assign busy_n   = req_fire || (fs_busy && !inst_data_ok);
    assign full_n   = !br_taken && ((inst_data_ok && !fs_cancel) || (fs_full && !ds_allowin));

    assign inst_req       = fs_req;
    assign inst_wr        = 1'b0;
    assign inst_addr      = pc;
    assign inst_wdata     = '0;
    assign fs_to_ds_valid = fs_full;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc        <= `RESET_PC;
            fs_req    <= 1'b0;
            fs_busy   <= 1'b0;
            fs_full   <= 1'b0;
            fs_cancel <= 1'b0;
            fs_redir  <= 1'b0;
        end else begin
            fs_req  <= !busy_n && !full_n;  // one fetch at a time
            fs_busy <= busy_n;
            fs_full <= full_n;
            if (br_taken && (fs_req || (fs_busy && !inst_data_ok))) begin
                fs_cancel <= 1'b1;  // drop the stale response
            end else if (inst_data_ok) begin
                fs_cancel <= 1'b0;
            end
            if (br_taken && req_wait) begin
                fs_redir <= 1'b1;  // addr held until accepted
            end else if (req_fire) begin
                fs_redir <= 1'b0;
            end
            if (br_taken && !req_wait) begin
                pc <= br_target;
            end else if (req_fire) begin
                pc <= fs_redir ? redir_pc : pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (br_taken) begin
            redir_pc <= br_target;
        end
        if (req_fire) begin
            fs_pc <= pc;
        end
        if (inst_data_ok) begin
            fs_inst <= inst_rdata;
        end
    end
endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module reg_file (
    input  logic               clk,
    input  logic [`REG_AW-1:0] raddr1,
    output logic [`XLEN-1:0]   rdata1,
    input  logic [`REG_AW-1:0] raddr2,
    output logic [`XLEN-1:0]   rdata2,
    input  logic               we,
    input  logic [`REG_AW-1:0] waddr,
    input  logic [`XLEN-1:0]   wdata
);
    logic [`XLEN-1:0] rf [0:(1<<`REG_AW)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            rf[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];  // r0 always zero
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];
endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // decoded operation, OP_NOP covers bubbles and unknown words
    typedef enum logic [2:0] {
        OP_NOP,
        OP_ADD,
        OP_ADDI,
        OP_LD,
        OP_ST,
        OP_BEQ
    } op_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_INST,
        ARB_WAIT_DATA
    } arb_state_e;

endpackage

`default_nettype wire

//--- cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define XLEN      32
`define REG_AW    5
`define RESET_PC  32'h1c00_0000

// add.w matches inst[31:15]
`define OPC_ADD_W   17'b00000000000100000
// addi.w, ld.w, st.w match inst[31:22]
`define OPC_ADDI_W  10'b0000001010
`define OPC_LD_W    10'b0010100010
`define OPC_ST_W    10'b0010100110
// beq matches inst[31:26]
`define OPC_BEQ     6'b010110

`endif
